/* design/uart_pkg.sv */
`default_nettype none

// serial line timing, shared by receiver, transmitter and testbench
package uart_pkg;

   localparam int CLKS_PER_BIT = 16;               // clocks per serial bit
   localparam int HALF_BIT     = CLKS_PER_BIT / 2; // start bit checked at its centre

   // start + 8 data + stop
   localparam int FRAME_BITS   = 10;

   // bit timing counter, counts 0 .. CLKS_PER_BIT-1
   localparam int CNT_W        = $clog2(CLKS_PER_BIT);

endpackage

`default_nettype wire

/* design/core_pkg.sv */
`default_nettype none

package core_pkg;

   //////////////////////////////////////////////////////////////////////
   // widths

   localparam int CODE_DEPTH = 64;                 // program store bytes
   localparam int CODE_AW    = $clog2(CODE_DEPTH);
   localparam int DATA_W     = 8;
   localparam int DPTR_W     = 16;

   //////////////////////////////////////////////////////////////////////
   // opcodes of the kept subset

   localparam logic [DATA_W-1:0] OP_LJMP     = 8'h02; // ljmp addr16
   localparam logic [DATA_W-1:0] OP_INC_A    = 8'h04;
   localparam logic [DATA_W-1:0] OP_RRC      = 8'h13;
   localparam logic [DATA_W-1:0] OP_DEC_A    = 8'h14;
   localparam logic [DATA_W-1:0] OP_RL       = 8'h23;
   localparam logic [DATA_W-1:0] OP_ADD      = 8'h24; // add a,#imm
   localparam logic [DATA_W-1:0] OP_RLC      = 8'h33;
   localparam logic [DATA_W-1:0] OP_ADDC     = 8'h34; // addc a,#imm
   localparam logic [DATA_W-1:0] OP_JC       = 8'h40;
   localparam logic [DATA_W-1:0] OP_ORL      = 8'h44; // orl a,#imm
   localparam logic [DATA_W-1:0] OP_JNC      = 8'h50;
   localparam logic [DATA_W-1:0] OP_ANL      = 8'h54; // anl a,#imm
   localparam logic [DATA_W-1:0] OP_JZ       = 8'h60;
   localparam logic [DATA_W-1:0] OP_XRL      = 8'h64; // xrl a,#imm
   localparam logic [DATA_W-1:0] OP_JNZ      = 8'h70;
   localparam logic [DATA_W-1:0] OP_MOV_A    = 8'h74; // mov a,#imm
   localparam logic [DATA_W-1:0] OP_SJMP     = 8'h80;
   localparam logic [DATA_W-1:0] OP_MOV_DPTR = 8'h90; // mov dptr,#imm16
   localparam logic [DATA_W-1:0] OP_SUBB     = 8'h94; // subb a,#imm
   localparam logic [DATA_W-1:0] OP_CLR_C    = 8'hC3;
   localparam logic [DATA_W-1:0] OP_SETB_C   = 8'hD3;
   localparam logic [DATA_W-1:0] OP_MOVX_RD  = 8'hE0; // movx a,@dptr
   localparam logic [DATA_W-1:0] OP_CLR_A    = 8'hE4;
   localparam logic [DATA_W-1:0] OP_MOVX_WR  = 8'hF0; // movx @dptr,a
   localparam logic [DATA_W-1:0] OP_CPL_A    = 8'hF4;

   //////////////////////////////////////////////////////////////////////
   // movx address map

   localparam logic [DPTR_W-1:0] IO_TX_STATUS = 16'h0200; // read: tx busy
   localparam logic [DPTR_W-1:0] IO_TX_DATA   = 16'h0201; // write: send A

   // instruction sequencer
   typedef enum logic [2:0] {
      FETCH,
      DECODE0,
      DECODE1,
      DECODE2,
      EXECUTE
   } seq_state_t;

endpackage

`default_nettype wire

/* design/uart_rx.sv */
`default_nettype none

module uart_rx (
   input  wire                           i_clk,
   input  wire                           i_nrst,
   input  wire                           i_rx,
   output logic                          o_valid,
   output logic [core_pkg::DATA_W-1:0]   o_byte
);

   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;
   typedef logic [uart_pkg::CNT_W-1:0] cnt_t;

   logic [2:0]                  sync;     // [1] is the usable sample, [2] the one before
   logic                        rx_s;
   logic                        fall;
   rx_state_t                   state;
   cnt_t                        cnt;
   logic                        full_tick;
   logic                        half_tick;
   logic [core_pkg::DATA_W-1:0] shift;

   assign rx_s      = sync[1];
   assign fall      = sync[2] & ~sync[1];
   assign full_tick = (cnt == cnt_t'(uart_pkg::CLKS_PER_BIT - 1));
   assign half_tick = (cnt == cnt_t'(uart_pkg::HALF_BIT - 1));

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         sync    <= 3'b111;   // line idles high
         state   <= RX_IDLE;
         cnt     <= '0;
         o_valid <= 1'b0;
      end else begin
         sync    <= {sync[1:0], i_rx};
         o_valid <= 1'b0;
         cnt     <= (state == RX_IDLE) ? '0 : cnt + 1'b1;
         case (state)
            RX_IDLE: begin
               if (fall) state <= RX_START;
            end
            RX_START: begin
               if (half_tick) begin
                  cnt   <= '0;
                  state <= rx_s ? RX_IDLE : RX_DATA;   // glitch goes back to idle
               end
            end
            RX_DATA: begin
               if (full_tick) begin
                  cnt <= '0;
                  if (shift[0]) state <= RX_STOP;      // marker reached bit 0
               end
            end
            RX_STOP: begin
               if (full_tick) begin
                  o_valid <= rx_s;                     // drop frames with a bad stop bit
                  state   <= RX_IDLE;
               end
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

   // data shifts in lsb first behind a marker bit
   always_ff @(posedge i_clk) begin
      if (state == RX_IDLE && fall) begin
         shift <= {1'b1, {(core_pkg::DATA_W - 1){1'b0}}};
      end else if (state == RX_DATA && full_tick) begin
         shift <= {rx_s, shift[core_pkg::DATA_W-1:1]};
      end
   end

   assign o_byte = shift;

endmodule

`default_nettype wire

/* design/uart_tx.sv */
`default_nettype none

module uart_tx (
   input  wire                           i_clk,
   input  wire                           i_nrst,
   input  wire                           i_start,
   input  wire  [core_pkg::DATA_W-1:0]   i_byte,
   output logic                          o_tx,
   output logic                          o_busy
);

   typedef enum logic [1:0] {TX_IDLE, TX_START, TX_SEND} tx_state_t;
   typedef logic [uart_pkg::CNT_W-1:0] cnt_t;
   typedef logic [$clog2(uart_pkg::FRAME_BITS)-1:0] bit_t;

   tx_state_t                   state;
   cnt_t                        cnt;
   bit_t                        bit_cnt;   // bits finished in this frame
   logic                        tick;
   logic [core_pkg::DATA_W-1:0] shift;

   assign tick = (cnt == cnt_t'(uart_pkg::CLKS_PER_BIT - 1));

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state   <= TX_IDLE;
         cnt     <= '0;
         bit_cnt <= '0;
      end else begin
         case (state)
            TX_IDLE: begin
               cnt     <= '0;
               bit_cnt <= '0;
               if (i_start) state <= TX_START;
            end
            TX_START: begin
               cnt <= tick ? '0 : cnt + 1'b1;
               if (tick) begin
                  bit_cnt <= bit_cnt + 1'b1;
                  state   <= TX_SEND;
               end
            end
            TX_SEND: begin
               cnt <= tick ? '0 : cnt + 1'b1;
               if (tick) begin
                  bit_cnt <= bit_cnt + 1'b1;
                  if (bit_cnt == bit_t'(uart_pkg::FRAME_BITS - 1)) state <= TX_IDLE;
               end
            end
            default: state <= TX_IDLE;
         endcase
      end
   end

   // ones fill in from the top, so the stop bit comes out last
   always_ff @(posedge i_clk) begin
      if (state == TX_IDLE && i_start) begin
         shift <= i_byte;
      end else if (state == TX_SEND && tick) begin
         shift <= {1'b1, shift[core_pkg::DATA_W-1:1]};
      end
   end

   always_comb begin
      case (state)
         TX_IDLE:  o_tx = 1'b1;
         TX_START: o_tx = 1'b0;
         default:  o_tx = shift[0];
      endcase
   end

   assign o_busy = (state != TX_IDLE);

endmodule

`default_nettype wire

/* design/program_store.sv */
`default_nettype none

module program_store (
   input  wire                           i_clk,
   input  wire                           i_nrst,
   input  wire                           i_wr_valid,
   input  wire  [core_pkg::DATA_W-1:0]   i_wr_byte,
   input  wire  [core_pkg::CODE_AW-1:0]  i_rd_addr,
   output logic [core_pkg::DATA_W-1:0]   o_rd_data,
   output logic                          o_loaded
);

   typedef logic [core_pkg::CODE_AW-1:0] addr_t;

   logic [core_pkg::DATA_W-1:0] mem [core_pkg::CODE_DEPTH];
   addr_t                       load_addr;
   logic                        load_wr;

   assign load_wr = i_wr_valid & ~o_loaded;   // bytes after a full load are ignored

   // load pointer and done flag
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         load_addr <= '0;
         o_loaded  <= 1'b0;
      end else if (load_wr) begin
         load_addr <= load_addr + 1'b1;
         if (load_addr == addr_t'(core_pkg::CODE_DEPTH - 1)) o_loaded <= 1'b1;
      end
   end

   always_ff @(posedge i_clk) begin
      if (load_wr) mem[load_addr] <= i_wr_byte;
      o_rd_data <= mem[i_rd_addr];   // one cycle read latency
   end

endmodule

`default_nettype wire

/* design/core_alu.sv */
`default_nettype none

module core_alu (
   input  wire  [core_pkg::DATA_W-1:0]   i_op,
   input  wire  [core_pkg::DATA_W-1:0]   i_acc,
   input  wire                           i_carry,
   input  wire  [core_pkg::DATA_W-1:0]   i_imm,
   input  wire                           i_tx_busy,
   input  wire  [core_pkg::DPTR_W-1:0]   i_dptr,
   output logic [core_pkg::DATA_W-1:0]   o_acc,
   output logic                          o_carry
);

   localparam int W = core_pkg::DATA_W;

   logic [W:0] add_sum;   // top bit is the carry out
   logic [W:0] addc_sum;
   logic [W:0] sub_diff;  // top bit is the borrow

   assign add_sum  = {1'b0, i_acc} + {1'b0, i_imm};
   assign addc_sum = add_sum + {{W{1'b0}}, i_carry};
   assign sub_diff = {1'b0, i_acc} - {1'b0, i_imm} - {{W{1'b0}}, i_carry};

   always_comb begin
      o_acc   = i_acc;
      o_carry = i_carry;
      case (i_op)
         core_pkg::OP_MOV_A:  o_acc = i_imm;
         core_pkg::OP_ADD:    {o_carry, o_acc} = add_sum;
         core_pkg::OP_ADDC:   {o_carry, o_acc} = addc_sum;
         core_pkg::OP_SUBB:   {o_carry, o_acc} = sub_diff;
         core_pkg::OP_ANL:    o_acc = i_acc & i_imm;
         core_pkg::OP_ORL:    o_acc = i_acc | i_imm;
         core_pkg::OP_XRL:    o_acc = i_acc ^ i_imm;
         core_pkg::OP_CLR_A:  o_acc = '0;
         core_pkg::OP_CPL_A:  o_acc = ~i_acc;
         core_pkg::OP_INC_A:  o_acc = i_acc + 1'b1;   // wraps, carry kept
         core_pkg::OP_DEC_A:  o_acc = i_acc - 1'b1;
         core_pkg::OP_RL:     o_acc = {i_acc[W-2:0], i_acc[W-1]};
         core_pkg::OP_RLC: begin
            o_acc   = {i_acc[W-2:0], i_carry};
            o_carry = i_acc[W-1];
         end
         core_pkg::OP_RRC: begin
            o_acc   = {i_carry, i_acc[W-1:1]};
            o_carry = i_acc[0];
         end
         core_pkg::OP_CLR_C:  o_carry = 1'b0;
         core_pkg::OP_SETB_C: o_carry = 1'b1;
         core_pkg::OP_MOVX_RD: begin
            // only the tx status register is readable
            o_acc = (i_dptr == core_pkg::IO_TX_STATUS) ? {{(W - 1){1'b0}}, i_tx_busy} : '0;
         end
         default: begin
            o_acc   = i_acc;
            o_carry = i_carry;
         end
      endcase
   end

endmodule

`default_nettype wire

/* design/core_control.sv */
`default_nettype none

module core_control (
   input  wire                           i_clk,
   input  wire                           i_nrst,
   input  wire                           i_loaded,
   input  wire  [core_pkg::DATA_W-1:0]   i_code_data,
   input  wire                           i_tx_busy,
   output logic [core_pkg::CODE_AW-1:0]  o_code_addr,
   output logic                          o_tx_start,
   output logic [core_pkg::DATA_W-1:0]   o_tx_byte
);

   // operand bytes that follow an opcode, unknown opcodes have none
   function automatic logic [1:0] operand_bytes(input logic [core_pkg::DATA_W-1:0] code);
      logic [1:0] n;
      case (code)
         core_pkg::OP_MOV_A, core_pkg::OP_ADD, core_pkg::OP_ADDC, core_pkg::OP_SUBB,
         core_pkg::OP_ANL, core_pkg::OP_ORL, core_pkg::OP_XRL, core_pkg::OP_SJMP,
         core_pkg::OP_JZ, core_pkg::OP_JNZ, core_pkg::OP_JC, core_pkg::OP_JNC: n = 2'd1;
         core_pkg::OP_MOV_DPTR, core_pkg::OP_LJMP:                           n = 2'd2;
         default:                                                            n = 2'd0;
      endcase
      return n;
   endfunction

   core_pkg::seq_state_t         state;
   core_pkg::seq_state_t         state_next;
   logic [core_pkg::CODE_AW-1:0] pc;
   logic [core_pkg::CODE_AW-1:0] pc_next;
   logic [core_pkg::CODE_AW-1:0] rel_target;
   logic [core_pkg::DATA_W-1:0]  op;
   logic [core_pkg::DATA_W-1:0]  imm1;
   logic [core_pkg::DATA_W-1:0]  imm2;
   logic [core_pkg::DATA_W-1:0]  acc;
   logic [core_pkg::DATA_W-1:0]  alu_acc;
   logic                         carry;
   logic                         alu_carry;
   logic [core_pkg::DPTR_W-1:0]  dptr;
   logic [1:0]                   extra_d0;   // from the opcode on the bus
   logic [1:0]                   extra_op;   // from the latched opcode
   logic                         is_exec;
   logic                         pc_inc;
   logic                         take_rel;

   //////////////////////////////////////////////////////////////////////
   // sequencer

   assign extra_d0 = operand_bytes(i_code_data);
   assign extra_op = operand_bytes(op);
   assign is_exec  = (state == core_pkg::EXECUTE);

   always_comb begin
      state_next = state;
      case (state)
         core_pkg::FETCH:   if (i_loaded) state_next = core_pkg::DECODE0;
         core_pkg::DECODE0: state_next = (extra_d0 != 2'd0) ? core_pkg::DECODE1 : core_pkg::EXECUTE;
         core_pkg::DECODE1: state_next = (extra_op == 2'd2) ? core_pkg::DECODE2 : core_pkg::EXECUTE;
         core_pkg::DECODE2: state_next = core_pkg::EXECUTE;
         default:           state_next = core_pkg::FETCH;
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // program counter, points past the whole instruction by execute

   assign pc_inc = (state == core_pkg::FETCH   && i_loaded) |
                   (state == core_pkg::DECODE0 && extra_d0 != 2'd0) |
                   (state == core_pkg::DECODE1 && extra_op == 2'd2);

   assign rel_target = pc + imm1[core_pkg::CODE_AW-1:0];   // wraps mod code depth

   always_comb begin
      case (op)
         core_pkg::OP_SJMP: take_rel = 1'b1;
         core_pkg::OP_JZ:   take_rel = (acc == '0);
         core_pkg::OP_JNZ:  take_rel = (acc != '0);
         core_pkg::OP_JC:   take_rel = carry;
         core_pkg::OP_JNC:  take_rel = ~carry;
         default:           take_rel = 1'b0;
      endcase
   end

   always_comb begin
      if (is_exec && take_rel) pc_next = rel_target;
      else if (is_exec && op == core_pkg::OP_LJMP) pc_next = imm2[core_pkg::CODE_AW-1:0];
      else if (pc_inc) pc_next = pc + 1'b1;
      else pc_next = pc;
   end

   //////////////////////////////////////////////////////////////////////
   // registers

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= core_pkg::FETCH;
         pc    <= '0;
         op    <= '0;   // 00h behaves as nop
         acc   <= '0;
         carry <= 1'b0;
         dptr  <= '0;
      end else begin
         state <= state_next;
         pc    <= pc_next;
         if (state == core_pkg::DECODE0) op <= i_code_data;
         if (is_exec) begin
            acc   <= alu_acc;
            carry <= alu_carry;
            if (op == core_pkg::OP_MOV_DPTR) dptr <= {imm1, imm2};   // high byte first
         end
      end
   end

   always_ff @(posedge i_clk) begin
      if (state == core_pkg::DECODE1) imm1 <= i_code_data;
      if (state == core_pkg::DECODE2) imm2 <= i_code_data;
   end

   core_alu u_alu (
      .i_op      (op),
      .i_acc     (acc),
      .i_carry   (carry),
      .i_imm     (imm1),
      .i_tx_busy (i_tx_busy),
      .i_dptr    (dptr),
      .o_acc     (alu_acc),
      .o_carry   (alu_carry)
   );

   assign o_code_addr = pc;
   assign o_tx_start  = is_exec & (op == core_pkg::OP_MOVX_WR) & (dptr == core_pkg::IO_TX_DATA);
   assign o_tx_byte   = acc;

endmodule

`default_nettype wire

/* design/mcu51_top.sv */
`default_nettype none

module mcu51_top (
   input  wire    i_clk,
   input  wire    i_nrst,
   input  wire    i_uart_rx,
   output logic   o_uart_tx
);

   logic                         rx_valid;
   logic [core_pkg::DATA_W-1:0]  rx_byte;
   logic [core_pkg::CODE_AW-1:0] code_addr;
   logic [core_pkg::DATA_W-1:0]  code_data;
   logic                         loaded;     // program store full, core may run
   logic                         tx_start;
   logic [core_pkg::DATA_W-1:0]  tx_byte;
   logic                         tx_busy;

   // program download path
   uart_rx u_uart_rx (
      .i_clk   (i_clk),
      .i_nrst  (i_nrst),
      .i_rx    (i_uart_rx),
      .o_valid (rx_valid),
      .o_byte  (rx_byte)
   );

   program_store u_program_store (
      .i_clk      (i_clk),
      .i_nrst     (i_nrst),
      .i_wr_valid (rx_valid),
      .i_wr_byte  (rx_byte),
      .i_rd_addr  (code_addr),
      .o_rd_data  (code_data),
      .o_loaded   (loaded)
   );

   core_control u_core (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_loaded    (loaded),
      .i_code_data (code_data),
      .i_tx_busy   (tx_busy),
      .o_code_addr (code_addr),
      .o_tx_start  (tx_start),
      .o_tx_byte   (tx_byte)
   );

   // result output
   uart_tx u_uart_tx (
      .i_clk   (i_clk),
      .i_nrst  (i_nrst),
      .i_start (tx_start),
      .i_byte  (tx_byte),
      .o_tx    (o_uart_tx),
      .o_busy  (tx_busy)
   );

endmodule

`default_nettype wire

/* testbench/tb_uart_monitor.sv */
`default_nettype none

module tb_uart_monitor (
   input wire i_clk,
   input wire i_tx
);

   string       name;
   logic [31:0] exp_bytes;    // first byte in the top lane
   int          exp_n;
   int          got_n;
   int          errs;
   int          pass_n = 0;
   int          fail_n = 0;
   logic [7:0]  rx_byte;
   logic        loading = 1'b0;   // driver is in reset or program load
   logic        idle_bad;

   task automatic begin_test(input string n, input int cnt, input logic [31:0] bytes);
      name      = n;
      exp_n     = cnt;
      exp_bytes = bytes;
      got_n     = 0;
      errs      = 0;
      idle_bad  = 1'b0;
   endtask

   // line must stay high while this is on
   task automatic watch_idle(input logic on);
      loading <= on;
   endtask

   task automatic end_test();
      if (got_n < exp_n) begin
         $display("%s: only %0d of %0d bytes were received", name, got_n, exp_n);
         errs++;
      end
      if (errs == 0) begin
         $display("%s: passed", name);
         pass_n++;
      end else begin
         $display("%s: failed with %0d errors", name, errs);
         fail_n++;
      end
   endtask

   task automatic check_byte(input logic [7:0] b);
      logic [7:0] want;
      want = exp_bytes[31 - 8 * got_n -: 8];
      if (got_n >= exp_n) begin
         $display("%s: extra byte %02h was sent", name, b);
         errs++;
      end else if (b !== want) begin
         $display("** Error %s: byte %0d expected %02h actual %02h", name, got_n, want, b);
         errs++;
      end
      got_n++;
   endtask

   // idle line through reset and load, reported once per test
   always @(negedge i_clk) begin
      if (loading && i_tx !== 1'b1 && !idle_bad) begin
         $display("%s: tx line left idle during reset or load", name);
         idle_bad = 1'b1;
         errs++;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // frame decoder, samples at bit centres
   initial begin
      forever begin
         @(negedge i_clk);
         if (i_tx === 1'b0) begin
            repeat (uart_pkg::HALF_BIT) @(negedge i_clk);   // centre of start bit
            for (int i = 0; i < 8; i++) begin
               repeat (uart_pkg::CLKS_PER_BIT) @(negedge i_clk);
               rx_byte[i] = i_tx;   // lsb first
            end
            repeat (uart_pkg::CLKS_PER_BIT) @(negedge i_clk);
            if (i_tx !== 1'b1) begin
               $display("%s: stop bit of byte %0d was low", name, got_n);
               errs++;
            end
            check_byte(rx_byte);
         end
      end
   end

endmodule

`default_nettype wire

/* testbench/tb_mcu51.sv */
`default_nettype none

module tb_mcu51;

   localparam int NUM_TESTS  = 6;
   localparam int FRAME_CLKS = 10 * uart_pkg::CLKS_PER_BIT;
   localparam int MAX_CYCLES = NUM_TESTS * (core_pkg::CODE_DEPTH + 4) * FRAME_CLKS * 2;

   logic        clk;
   logic        nrst;
   logic        rx;
   logic        tx;
   int          cycles = 0;
   int          wait_cnt;
   string       names [NUM_TESTS];
   string       progs [NUM_TESTS];   // hex text, missing bytes are 00h
   int          counts [NUM_TESTS];
   logic [31:0] exp_words [NUM_TESTS];

   mcu51_top DUT (.i_clk(clk), .i_nrst(nrst), .i_uart_rx(rx), .o_uart_tx(tx));

   tb_uart_monitor MON (.i_clk(clk), .i_tx(tx));

   function automatic logic [3:0] hex_val(input logic [7:0] c);
      return (c <= 8'h39) ? 4'(c - 8'h30) : 4'(c - 8'h37);
   endfunction

   function automatic logic [7:0] prog_byte(input string s, input int a);
      if (2 * a + 1 >= s.len()) return 8'h00;
      return {hex_val(s[2 * a]), hex_val(s[2 * a + 1])};
   endfunction

   // start, 8 data bits lsb first, stop
   task automatic send_frame(input logic [7:0] b);
      logic [9:0] bits;
      bits = {1'b1, b, 1'b0};
      for (int i = 0; i < 10; i++) begin
         rx = bits[i];
         repeat (uart_pkg::CLKS_PER_BIT) @(negedge clk);
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: run stopped after %0d cycles", cycles);
         $display("** FAIL **");
         $finish;
      end
   end

   initial begin
      nrst = 1'b0;
      rx   = 1'b1;   // line idle
      //////////////////////////////////////////////////////////////////////
      // test table
      names  = '{"idle_load", "arith_carry", "logic_rotate", "dec_loop", "branches",
                 "busy_poll"};
      progs[0] = "745A900201F080FE";
      progs[1] = {"74F02420900201F0", "900200E070FD74803480900201F0",
                  "900200E070FD74109405900201F0", "900200E070FD74039405900201F0", "80FE"};
      progs[2] = {"74F0543C440564FF900201F0", "900200E070FD748123D333F4900201F0",
                  "900200E070FD7481C31313900201F0", "80FE"};
      progs[3] = "7005740490020114700280FEF0";   // body wraps through the 00h padding
      progs[4] = {"D3400280FE50FCC3500280FEE4600280FE", "90020102125A74EEF074A5F080FE"};
      progs[5] = {"900200E070FD7431900201F0", "900200E070FD74C4900201F0",
                  "900200E070FD7407900201F0", "900200E070FD74E8900201F0", "80FE"};
      counts    = '{1, 4, 3, 3, 1, 4};
      exp_words = '{32'h5A000000, 32'h10010AFE, 32'hCAF8A000, 32'h03020100,
                    32'hA5000000, 32'h31C407E8};

      for (int t = 0; t < NUM_TESTS; t++) begin
         MON.begin_test(names[t], counts[t], exp_words[t]);
         MON.watch_idle(1'b1);
         @(negedge clk);
         nrst = 1'b0;
         repeat (2) @(negedge clk);
         nrst = 1'b1;
         for (int a = 0; a < core_pkg::CODE_DEPTH; a++) send_frame(prog_byte(progs[t], a));
         MON.watch_idle(1'b0);
         wait_cnt = 0;
         while (MON.got_n < counts[t] && wait_cnt < 8 * FRAME_CLKS) begin
            @(negedge clk);
            wait_cnt++;
         end
         repeat (2 * FRAME_CLKS) @(negedge clk);   // quiet gap catches extra bytes
         MON.end_test();
      end

      $display("tests passed: %0d, failed: %0d", MON.pass_n, MON.fail_n);
      if (MON.fail_n == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* sources.f */
design/uart_pkg.sv
design/core_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/program_store.sv
design/core_alu.sv
design/core_control.sv
design/mcu51_top.sv
testbench/tb_uart_monitor.sv
testbench/tb_mcu51.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f sources.f --top-module tb_mcu51 -o sim_mcu51
out=$(./obj_dir/sim_mcu51)
echo "$out"
echo "$out" | grep -qx '\*\* PASS \*\*'
